// ==== adc_pkg.sv ====
// Shared definitions for the two-lane SAR ADC capture path
// Holds the default sample width and buffer depth, the serial engine
// state encoding and the lane identifier used by the arbiter and buffer

package adc_pkg;

  // ****************************************
  // Default sizes
  // ****************************************

  // Bits per sample shifted out of each ADC lane
  localparam int DATA_WIDTH_DEF = 16;

  // Entries in the sample buffer, must be a power of two
  localparam int DEPTH_DEF = 16;

  // ****************************************
  // Encodings
  // ****************************************

  // Serial readout engine states
  // SPI_HIGH and SPI_LOW are the two halves of one serial bit
  typedef enum logic [1:0] {
    SPI_IDLE = 2'd0,
    SPI_HIGH = 2'd1,
    SPI_LOW  = 2'd2,
    SPI_END  = 2'd3
  } spi_state_t;

  // Source lane of a buffered sample
  // Lane A has priority in the arbiter and is stored as tag 0
  typedef enum logic {
    LANE_A = 1'b0,
    LANE_B = 1'b1
  } lane_t;

endpackage

// ==== adc_spi_engine.sv ====
// Serial readout engine for one ADC conversion frame
// Drops chip select on an accepted start, runs DATA_WIDTH serial clock
// pulses and tells the lane receivers when to sample and when the frame ends

module adc_spi_engine #(
  parameter int DATA_WIDTH = adc_pkg::DATA_WIDTH_DEF
) (
  input  logic clk,
  input  logic rstn,
  input  logic start,
  input  logic xfer_req,
  output logic cs_n,
  output logic sclk,
  output logic sample_en,
  output logic frame_done,
  output logic busy
);

  import adc_pkg::*;

  localparam int CNT_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_WIDTH - 1);

  spi_state_t       state;
  logic [CNT_W-1:0] bit_cnt;

  // ****************************************
  // Frame FSM
  // ****************************************

  // All pin outputs are registered so they change on the state transition
  // Each bit is one SPI_HIGH cycle followed by one SPI_LOW cycle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= SPI_IDLE;
      bit_cnt    <= '0;
      cs_n       <= 1'b1;
      sclk       <= 1'b0;
      sample_en  <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      // Strobes default low and are raised only on their transition
      sample_en  <= 1'b0;
      frame_done <= 1'b0;
      case (state)
        SPI_IDLE: begin
          // A start is only taken when the buffer can hold both lanes
          if (start && xfer_req) begin
            state     <= SPI_HIGH;
            bit_cnt   <= '0;
            cs_n      <= 1'b0;
            sclk      <= 1'b1;
            sample_en <= 1'b1;
          end
        end
        SPI_HIGH: begin
          state <= SPI_LOW;
          sclk  <= 1'b0;
        end
        SPI_LOW: begin
          if (bit_cnt == LAST_BIT) begin
            // Last bit is already in the lanes, close the frame
            state      <= SPI_END;
            cs_n       <= 1'b1;
            frame_done <= 1'b1;
          end else begin
            state     <= SPI_HIGH;
            bit_cnt   <= bit_cnt + 1'b1;
            sclk      <= 1'b1;
            sample_en <= 1'b1;
          end
        end
        SPI_END: begin
          state <= SPI_IDLE;
        end
        default: begin
          state <= SPI_IDLE;
        end
      endcase
    end
  end

  // Host sees the engine busy for the whole frame including SPI_END
  assign busy = (state != SPI_IDLE);

  // Lanes must never shift in a bit outside an open frame
  a_sample_in_frame: assert property (@(posedge clk) disable iff (!rstn)
    sample_en |-> !cs_n);

endmodule

// ==== adc_lane_rx.sv ====
// Serial receiver for one ADC data lane
// Shifts the lane's sdo bits in MSB first and presents the finished
// sample as a one-cycle stream beat once the frame has ended

module adc_lane_rx #(
  parameter int DATA_WIDTH = adc_pkg::DATA_WIDTH_DEF
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  sample_en,
  input  logic                  frame_done,
  input  logic                  sdo,
  output logic [DATA_WIDTH-1:0] m_axis_data,
  output logic                  m_axis_valid
);

  // Partially assembled sample
  logic [DATA_WIDTH-1:0] shift_q;

  // ****************************************
  // Shift register
  // ****************************************

  // The first bit ends up in the MSB after DATA_WIDTH shifts
  always_ff @(posedge clk) begin
    if (sample_en) begin
      shift_q <= {shift_q[DATA_WIDTH-2:0], sdo};
    end
  end

  // ****************************************
  // Stream output
  // ****************************************

  // The word is captured on frame_done so it stays stable while the
  // next frame refills the shift register
  always_ff @(posedge clk) begin
    if (frame_done) begin
      m_axis_data <= shift_q;
    end
  end

  // Valid is a single-cycle strobe the cycle after frame_done
  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_axis_valid <= 1'b0;
    end else begin
      m_axis_valid <= frame_done;
    end
  end

endmodule

// ==== adc_maxis2wrfifo.sv ====
// Stream to buffer write adapter for one ADC lane
// Turns each valid stream beat into a registered write strobe, attaches
// the sync tag to the first sample after a sync request and relays the
// buffer's transfer request back to the stream side

module adc_maxis2wrfifo #(
  parameter int DATA_WIDTH = adc_pkg::DATA_WIDTH_DEF
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  sync_in,
  input  logic [DATA_WIDTH-1:0] m_axis_data,
  input  logic                  m_axis_valid,
  output logic                  m_axis_xfer_req,
  output logic                  fifo_wr_en,
  output logic [DATA_WIDTH-1:0] fifo_wr_data,
  output logic                  fifo_wr_sync,
  input  logic                  fifo_wr_xfer_req
);

  // Set by sync_in and held until the next sample is written
  logic sync_pending;

  // ****************************************
  // Control and tag
  // ****************************************

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sync_pending    <= 1'b0;
      fifo_wr_en      <= 1'b0;
      fifo_wr_sync    <= 1'b0;
      m_axis_xfer_req <= 1'b0;
    end else begin
      // Every beat is accepted, there is no back-pressure
      fifo_wr_en      <= m_axis_valid;
      m_axis_xfer_req <= fifo_wr_xfer_req;
      // Tag rides with the write strobe of the first sample only
      fifo_wr_sync    <= m_axis_valid & sync_pending;
      // A fresh sync request wins over a clear on the same cycle
      if (sync_in) begin
        sync_pending <= 1'b1;
      end else if (m_axis_valid) begin
        sync_pending <= 1'b0;
      end
    end
  end

  // Sample payload follows the strobe, qualified by fifo_wr_en
  always_ff @(posedge clk) begin
    if (m_axis_valid) begin
      fifo_wr_data <= m_axis_data;
    end
  end

endmodule

// ==== sample_arbiter.sv ====
// Write arbiter for the shared sample buffer
// Merges the write strobes of lanes A and B into one buffer port with
// lane A on fixed priority; a colliding lane B sample waits one cycle
// in a single-entry hold slot together with its sync tag

module sample_arbiter #(
  parameter int DATA_WIDTH = adc_pkg::DATA_WIDTH_DEF
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  a_wr_en,
  input  logic [DATA_WIDTH-1:0] a_wr_data,
  input  logic                  a_wr_sync,
  input  logic                  b_wr_en,
  input  logic [DATA_WIDTH-1:0] b_wr_data,
  input  logic                  b_wr_sync,
  output logic                  buf_wr_en,
  output logic [DATA_WIDTH-1:0] buf_wr_data,
  output logic                  buf_wr_sync,
  output adc_pkg::lane_t        buf_wr_lane
);

  import adc_pkg::*;

  // Lane B hold slot
  logic                  hold_vld;
  logic [DATA_WIDTH-1:0] hold_data;
  logic                  hold_sync;

  // ****************************************
  // Grant and hold
  // ****************************************

  // Order of service: lane A, then the held entry, then a direct lane B
  // A held entry always goes out before a newer lane B strobe
  always_ff @(posedge clk) begin
    if (!rstn) begin
      buf_wr_en   <= 1'b0;
      buf_wr_sync <= 1'b0;
      buf_wr_lane <= LANE_A;
      hold_vld    <= 1'b0;
    end else begin
      buf_wr_en <= a_wr_en | b_wr_en | hold_vld;
      if (a_wr_en) begin
        buf_wr_data <= a_wr_data;
        buf_wr_sync <= a_wr_sync;
        buf_wr_lane <= LANE_A;
        // Lane B lost the tie and parks its sample
        if (b_wr_en) begin
          hold_vld  <= 1'b1;
          hold_data <= b_wr_data;
          hold_sync <= b_wr_sync;
        end
      end else if (hold_vld) begin
        buf_wr_data <= hold_data;
        buf_wr_sync <= hold_sync;
        buf_wr_lane <= LANE_B;
        hold_vld    <= b_wr_en;
        if (b_wr_en) begin
          hold_data <= b_wr_data;
          hold_sync <= b_wr_sync;
        end
      end else if (b_wr_en) begin
        buf_wr_data <= b_wr_data;
        buf_wr_sync <= b_wr_sync;
        buf_wr_lane <= LANE_B;
      end
    end
  end

  // Frame spacing guarantees the slot drains before lane B strobes again
  a_hold_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
    b_wr_en |-> !hold_vld);

endmodule

// ==== sample_buffer.sv ====
// Circular sample buffer shared by both ADC lanes
// Stores each sample with its sync tag and lane, serves host pops one
// entry at a time and requests transfers while two entries are free

module sample_buffer #(
  parameter int DATA_WIDTH = adc_pkg::DATA_WIDTH_DEF,
  parameter int DEPTH      = adc_pkg::DEPTH_DEF
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     capture_en,
  input  logic                     wr_en,
  input  logic [DATA_WIDTH-1:0]    wr_data,
  input  logic                     wr_sync,
  input  adc_pkg::lane_t           wr_lane,
  output logic                     xfer_req,
  input  logic                     rd_strobe,
  output logic                     rd_valid,
  output logic [DATA_WIDTH-1:0]    rd_data,
  output logic                     rd_sync,
  output adc_pkg::lane_t           rd_lane,
  output logic [$clog2(DEPTH):0]   level
);

  import adc_pkg::*;

  localparam int AW = $clog2(DEPTH);

  // Entry layout is {sync, lane, data}
  logic [DATA_WIDTH+1:0] mem [DEPTH];
  logic [AW-1:0]         wr_ptr;
  logic [AW-1:0]         rd_ptr;
  logic [AW:0]           count;
  logic                  full;
  logic                  empty;
  logic                  wr_ok;
  logic                  rd_ok;

  assign full  = (count == (AW+1)'(DEPTH));
  assign empty = (count == '0);
  // Writes while full are dropped and pops on empty are ignored
  assign wr_ok = wr_en & ~full;
  assign rd_ok = rd_strobe & ~empty;

  // A frame writes two entries, so a start needs two free slots
  assign xfer_req = capture_en && (count <= (AW+1)'(DEPTH - 2));
  assign level    = count;

  // Pointers wrap on their own because DEPTH is a power of two
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      rd_valid <= 1'b0;
    end else begin
      wr_ptr   <= wr_ptr + AW'(wr_ok);
      rd_ptr   <= rd_ptr + AW'(rd_ok);
      count    <= count + (AW+1)'(wr_ok) - (AW+1)'(rd_ok);
      rd_valid <= rd_ok;
    end
  end

  // Entry storage and the registered pop data
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= {wr_sync, wr_lane, wr_data};
    end
    if (rd_ok) begin
      rd_data <= mem[rd_ptr][DATA_WIDTH-1:0];
      rd_lane <= lane_t'(mem[rd_ptr][DATA_WIDTH]);
      rd_sync <= mem[rd_ptr][DATA_WIDTH+1];
    end
  end

  // Start gating should keep every write away from a full buffer
  a_no_write_when_full: assert property (@(posedge clk) disable iff (!rstn)
    wr_en |-> !full);

endmodule

// ==== adc_capture_top.sv ====
// Two-lane capture path for a simultaneous-sampling serial SAR ADC
// One serial engine reads both lanes in parallel, each lane feeds its
// own write adapter and both adapters share one buffer via an arbiter

module adc_capture_top #(
  parameter int DATA_WIDTH = adc_pkg::DATA_WIDTH_DEF,
  parameter int DEPTH      = adc_pkg::DEPTH_DEF
) (
  input  logic                   clk,
  input  logic                   rstn,
  // Host control
  input  logic                   start,
  input  logic                   sync_in,
  input  logic                   capture_en,
  input  logic                   rd_strobe,
  // ADC pins
  output logic                   cs_n,
  output logic                   sclk,
  input  logic                   sdo_a,
  input  logic                   sdo_b,
  // Host read side
  output logic                   rd_valid,
  output logic [DATA_WIDTH-1:0]  rd_data,
  output logic                   rd_sync,
  output adc_pkg::lane_t         rd_lane,
  output logic [$clog2(DEPTH):0] level,
  output logic                   busy
);

  import adc_pkg::*;

  logic                  sample_en;
  logic                  frame_done;
  logic [DATA_WIDTH-1:0] a_axis_data;
  logic                  a_axis_valid;
  logic [DATA_WIDTH-1:0] b_axis_data;
  logic                  b_axis_valid;
  logic                  a_xfer_req;
  logic                  b_xfer_req;
  logic                  a_wr_en;
  logic [DATA_WIDTH-1:0] a_wr_data;
  logic                  a_wr_sync;
  logic                  b_wr_en;
  logic [DATA_WIDTH-1:0] b_wr_data;
  logic                  b_wr_sync;
  logic                  buf_wr_en;
  logic [DATA_WIDTH-1:0] buf_wr_data;
  logic                  buf_wr_sync;
  lane_t                 buf_wr_lane;
  logic                  buf_xfer_req;

  // ****************************************
  // Serial front end
  // ****************************************

  // Lane A's registered transfer request gates new frames
  adc_spi_engine #(.DATA_WIDTH(DATA_WIDTH)) i_spi_engine (
    .clk(clk), .rstn(rstn), .start(start), .xfer_req(a_xfer_req),
    .cs_n(cs_n), .sclk(sclk), .sample_en(sample_en),
    .frame_done(frame_done), .busy(busy));

  adc_lane_rx #(.DATA_WIDTH(DATA_WIDTH)) i_lane_rx_a (
    .clk(clk), .rstn(rstn), .sample_en(sample_en), .frame_done(frame_done),
    .sdo(sdo_a), .m_axis_data(a_axis_data), .m_axis_valid(a_axis_valid));

  adc_lane_rx #(.DATA_WIDTH(DATA_WIDTH)) i_lane_rx_b (
    .clk(clk), .rstn(rstn), .sample_en(sample_en), .frame_done(frame_done),
    .sdo(sdo_b), .m_axis_data(b_axis_data), .m_axis_valid(b_axis_valid));

  // ****************************************
  // Write adapters, arbiter and buffer
  // ****************************************

  adc_maxis2wrfifo #(.DATA_WIDTH(DATA_WIDTH)) i_maxis2wrfifo_a (
    .clk(clk), .rstn(rstn), .sync_in(sync_in),
    .m_axis_data(a_axis_data), .m_axis_valid(a_axis_valid),
    .m_axis_xfer_req(a_xfer_req), .fifo_wr_en(a_wr_en),
    .fifo_wr_data(a_wr_data), .fifo_wr_sync(a_wr_sync),
    .fifo_wr_xfer_req(buf_xfer_req));

  adc_maxis2wrfifo #(.DATA_WIDTH(DATA_WIDTH)) i_maxis2wrfifo_b (
    .clk(clk), .rstn(rstn), .sync_in(sync_in),
    .m_axis_data(b_axis_data), .m_axis_valid(b_axis_valid),
    .m_axis_xfer_req(b_xfer_req), .fifo_wr_en(b_wr_en),
    .fifo_wr_data(b_wr_data), .fifo_wr_sync(b_wr_sync),
    .fifo_wr_xfer_req(buf_xfer_req));

  sample_arbiter #(.DATA_WIDTH(DATA_WIDTH)) i_sample_arbiter (
    .clk(clk), .rstn(rstn),
    .a_wr_en(a_wr_en), .a_wr_data(a_wr_data), .a_wr_sync(a_wr_sync),
    .b_wr_en(b_wr_en), .b_wr_data(b_wr_data), .b_wr_sync(b_wr_sync),
    .buf_wr_en(buf_wr_en), .buf_wr_data(buf_wr_data),
    .buf_wr_sync(buf_wr_sync), .buf_wr_lane(buf_wr_lane));

  sample_buffer #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) i_sample_buffer (
    .clk(clk), .rstn(rstn), .capture_en(capture_en),
    .wr_en(buf_wr_en), .wr_data(buf_wr_data), .wr_sync(buf_wr_sync),
    .wr_lane(buf_wr_lane), .xfer_req(buf_xfer_req), .rd_strobe(rd_strobe),
    .rd_valid(rd_valid), .rd_data(rd_data), .rd_sync(rd_sync),
    .rd_lane(rd_lane), .level(level));

  // Only lane A's copy gates the engine, so lane B's must never drift
  a_xfer_req_match: assert property (@(posedge clk) disable iff (!rstn)
    a_xfer_req == b_xfer_req);

endmodule

// ==== tb_adc_capture.sv ====
// Testbench for the two-lane ADC capture path
// Models both ADC serial lanes, runs random frames, sync pulses and
// start gating, and checks every popped entry against a reference queue

module tb_adc_capture;

  import adc_pkg::*;

  localparam int DATA_WIDTH = adc_pkg::DATA_WIDTH_DEF;
  localparam int DEPTH      = adc_pkg::DEPTH_DEF;
  localparam int CLK_HALF   = 2;
  localparam int DRIVE_DLY  = 1;
  // Longest wait for one frame or its writes, in cycles
  localparam int WAIT_LIMIT = 4 * DATA_WIDTH + 8;
  localparam int ORDER_ROUNDS = 4;
  localparam int SYNC_ROUNDS  = 3;
  localparam int SYNC_FRAMES  = 6;
  localparam int GATE_STARTS  = 4;
  // Worst case number of frames or gated starts over all tests
  localparam int FRAME_BUDGET = ORDER_ROUNDS * 7 + SYNC_ROUNDS * SYNC_FRAMES
                                + GATE_STARTS + DEPTH / 2 + 4;
  localparam int WATCHDOG_CYCLES = FRAME_BUDGET * (2 * DATA_WIDTH + 10) + 1000;

  logic                   clk;
  logic                   rstn;
  logic                   start;
  logic                   sync_in;
  logic                   capture_en;
  logic                   rd_strobe;
  logic                   cs_n;
  logic                   sclk;
  logic                   sdo_a;
  logic                   sdo_b;
  logic                   rd_valid;
  logic [DATA_WIDTH-1:0]  rd_data;
  logic                   rd_sync;
  lane_t                  rd_lane;
  logic [$clog2(DEPTH):0] level;
  logic                   busy;

  // Expected buffer contents in pop order
  logic [DATA_WIDTH-1:0] ref_data [$];
  lane_t                 ref_lane [$];
  logic                  ref_sync [$];
  // Mirrors the adapters' pending sync tag
  logic                  sync_model;

  adc_capture_top #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) i_adc_capture_top (
    .clk(clk), .rstn(rstn), .start(start), .sync_in(sync_in),
    .capture_en(capture_en), .rd_strobe(rd_strobe), .cs_n(cs_n), .sclk(sclk),
    .sdo_a(sdo_a), .sdo_b(sdo_b), .rd_valid(rd_valid), .rd_data(rd_data),
    .rd_sync(rd_sync), .rd_lane(rd_lane), .level(level), .busy(busy));

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  // ****************************************
  // ADC serial model
  // ****************************************

  // New words per frame, first bit out when cs_n falls and each next bit
  // shortly after the edge on which sclk falls
  initial begin : adc_model
    logic [DATA_WIDTH-1:0] word_a;
    logic [DATA_WIDTH-1:0] word_b;
    forever begin
      @(negedge cs_n);
      #DRIVE_DLY;
      word_a = DATA_WIDTH'($urandom());
      word_b = DATA_WIDTH'($urandom());
      // Both adapters see the same sync, so both samples share the tag
      ref_data.push_back(word_a);
      ref_lane.push_back(LANE_A);
      ref_sync.push_back(sync_model);
      ref_data.push_back(word_b);
      ref_lane.push_back(LANE_B);
      ref_sync.push_back(sync_model);
      sync_model = 1'b0;
      for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
        sdo_a = word_a[i];
        sdo_b = word_b[i];
        @(negedge sclk);
        #DRIVE_DLY;
      end
    end
  end

  // ****************************************
  // Checks and helpers
  // ****************************************

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Engine returns to idle at the end of the frame
  task automatic wait_idle();
    int waited;
    waited = 0;
    while (busy) begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) stop_with_error("Engine stayed busy after a frame");
    end
  endtask

  // Both lanes of the frame have reached the buffer
  task automatic wait_level(input int target);
    int waited;
    waited = 0;
    while (int'(level) != target) begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) stop_with_error("Buffer level never reached the model");
    end
  endtask

  task automatic pulse_start();
    next_cycle();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
  endtask

  // One accepted frame with a short random gap after it
  task automatic run_frame();
    pulse_start();
    check("frame busy", 32'd1, 32'(busy));
    wait_idle();
    wait_level(ref_data.size());
    repeat (2 + ($urandom() % 4)) next_cycle();
  endtask

  // A start that must be ignored for a whole frame time
  task automatic gated_start(input string name);
    logic [31:0] level_before;
    level_before = 32'(level);
    pulse_start();
    repeat (2 * DATA_WIDTH + 2) begin
      check({name, " cs_n"}, 32'd1, 32'(cs_n));
      check({name, " busy"}, 32'd0, 32'(busy));
      next_cycle();
    end
    check({name, " level"}, level_before, 32'(level));
  endtask

  task automatic pulse_sync();
    next_cycle();
    sync_in = 1'b1;
    sync_model = 1'b1;
    next_cycle();
    sync_in = 1'b0;
  endtask

  // Pop one entry and compare it with the oldest reference entry
  task automatic pop_check(input string name);
    if (ref_data.size() == 0) stop_with_error("Pop requested with an empty model queue");
    next_cycle();
    rd_strobe = 1'b1;
    next_cycle();
    rd_strobe = 1'b0;
    check({name, " rd_valid"}, 32'd1, 32'(rd_valid));
    check({name, " rd_data"}, 32'(ref_data.pop_front()), 32'(rd_data));
    check({name, " rd_lane"}, 32'(ref_lane.pop_front()), 32'(rd_lane));
    check({name, " rd_sync"}, 32'(ref_sync.pop_front()), 32'(rd_sync));
  endtask

  task automatic drain(input string name);
    while (ref_data.size() > 0) pop_check(name);
    next_cycle();
    check({name, " level"}, 32'd0, 32'(level));
  endtask

  // ****************************************
  // Watchdog
  // ****************************************

  initial begin : watchdog
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    $display("Simulation ran past its time limit");
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  // ****************************************
  // Test sequence
  // ****************************************

  initial begin : main
    void'($urandom(32'h5b759f9f));
    rstn       = 1'b0;
    start      = 1'b0;
    sync_in    = 1'b0;
    capture_en = 1'b1;
    rd_strobe  = 1'b0;
    sdo_a      = 1'b0;
    sdo_b      = 1'b0;
    sync_model = 1'b0;
    repeat (8) @(posedge clk);
    #DRIVE_DLY rstn = 1'b1;
    next_cycle();

    // Reset state, and a pop on the empty buffer returns nothing
    check("reset cs_n", 32'd1, 32'(cs_n));
    check("reset sclk", 32'd0, 32'(sclk));
    check("reset busy", 32'd0, 32'(busy));
    check("reset level", 32'd0, 32'(level));
    rd_strobe = 1'b1;
    next_cycle();
    rd_strobe = 1'b0;
    check("empty pop rd_valid", 32'd0, 32'(rd_valid));
    next_cycle();

    // Data order over random frame counts, A before B in every frame
    for (int r = 0; r < ORDER_ROUNDS; r++) begin
      repeat (1 + ($urandom() % 7)) run_frame();
      drain("order");
    end

    // Random sync pulses between frames
    for (int r = 0; r < SYNC_ROUNDS; r++) begin
      for (int f = 0; f < SYNC_FRAMES; f++) begin
        if ($urandom() % 2 == 1) pulse_sync();
        run_frame();
      end
      drain("sync");
    end

    // Capture disabled, starts must be ignored and a sync stays pending
    capture_en = 1'b0;
    repeat (3) next_cycle();
    for (int g = 0; g < GATE_STARTS; g++) begin
      if (g == 1) pulse_sync();
      gated_start("gate");
    end
    capture_en = 1'b1;
    repeat (3) next_cycle();
    run_frame();
    drain("gate resume");

    // Fill the buffer, then check that two free entries are needed
    for (int f = 0; f < DEPTH / 2; f++) run_frame();
    check("full level", 32'(DEPTH), 32'(level));
    gated_start("full");
    pop_check("full pop");
    gated_start("one free");
    pop_check("full pop");
    run_frame();
    check("refill level", 32'(DEPTH), 32'(level));
    drain("full drain");

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== all.f ====
adc_pkg.sv
adc_spi_engine.sv
adc_lane_rx.sv
adc_maxis2wrfifo.sv
sample_arbiter.sv
sample_buffer.sv
adc_capture_top.sv
tb_adc_capture.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the ADC capture testbench with Verilator.
# The result is decided by searching the log for the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_adc_capture

if ! verilator --binary --timing --assert --top-module tb_adc_capture \
    -f all.f --Mdir "$OBJ" -o "$BIN"; then
  echo "Verilator build failed"
  exit 1
fi

./"$OBJ"/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

exit 0
